// File: huf_lut_top.f
logic/huf_lut_pkg.sv
logic/huf_lut_wr_if.sv
logic/huf_lut_rd_if.sv
logic/huf_lut_bank.sv
logic/huf_lut_short.sv
logic/huf_lut_top.sv
verification/huf_lut_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f huf_lut_top.f \
   --top-module huf_lut_tb \
   -Mdir obj_dir -o huf_lut_sim

./obj_dir/huf_lut_sim 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
   exit 1
fi
exit 0

// File: verification/huf_lut_tb.sv
`timescale 1ns/1ps
`default_nettype none

module huf_lut_tb;

   typedef struct packed {
      logic data_val;
      logic miss;
      huf_lut_pkg::lut_entry_t [huf_lut_pkg::lanes-1:0] data;
      logic [huf_lut_pkg::hlit_w-1:0] hlit;
      logic [huf_lut_pkg::hdist_w-1:0] hdist;
   } resp_t;

   localparam int wait_limit = 20;

   logic clk;
   logic rst;
   logic wr1_valid;
   huf_lut_pkg::entry_kind_e wr1_kind;
   logic [huf_lut_pkg::addr_w-1:0] wr1_addr;
   huf_lut_pkg::wr_data_t wr1_data;
   logic wr1_done;
   logic [huf_lut_pkg::seq_w-1:0] wr1_seq_id;
   logic wr1_full;
   logic wr2_valid;
   huf_lut_pkg::entry_kind_e wr2_kind;
   logic [huf_lut_pkg::addr_w-1:0] wr2_addr;
   huf_lut_pkg::wr_data_t wr2_data;
   logic wr2_done;
   logic [huf_lut_pkg::seq_w-1:0] wr2_seq_id;
   logic wr2_full;
   logic rd;
   logic [huf_lut_pkg::lanes-1:0][huf_lut_pkg::addr_w-1:0] rd_addr;
   logic [huf_lut_pkg::seq_w-1:0] rd_seq_id;
   logic ret_ack;
   logic data_val;
   logic miss;
   huf_lut_pkg::lut_entry_t [huf_lut_pkg::lanes-1:0] rd_data;
   logic [huf_lut_pkg::hlit_w-1:0] hlit;
   logic [huf_lut_pkg::hdist_w-1:0] hdist;

   // model of both banks, index 0 is bank 1
   huf_lut_pkg::lut_entry_t model_mem [2][huf_lut_pkg::sym_count];
   logic [huf_lut_pkg::hlit_w-1:0] model_hlit [2];
   logic [huf_lut_pkg::hdist_w-1:0] model_hdist [2];
   logic [huf_lut_pkg::seq_w-1:0] model_seq [2];
   logic model_full [2];

   logic [15:0] lfsr_state;
   int errors;
   int checks;
   logic aborted;
   logic pend_valid;
   resp_t pend_exp;
   resp_t cur_exp;

   huf_lut_top dut_i (.*);

   always #4 clk = ~clk;

   // **********************************************************************
   // random source and reference model
   // **********************************************************************

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[14] ^ s[12] ^ s[3];
      return {s[14:0], fb};
   endfunction

   task automatic take_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[14:0], lfsr_state[0]};
      end
   endtask

   // the first full bank holding seq answers, bank 1 before bank 2
   function automatic resp_t ref_lookup(input logic [huf_lut_pkg::seq_w-1:0] seq,
                                        input logic [huf_lut_pkg::lanes-1:0][4:0] addr);
      resp_t r;
      r = '0;
      r.miss = 1'b1;
      for (int b = 0; b < 2; b++) begin
         if (model_full[b] && model_seq[b] == seq && !r.data_val) begin
            r.data_val = 1'b1;
            r.miss = 1'b0;
            for (int l = 0; l < huf_lut_pkg::lanes; l++) begin
               r.data[l] = model_mem[b][addr[l]];
            end
            r.hlit = model_hlit[b];
            r.hdist = model_hdist[b];
         end
      end
      return r;
   endfunction

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      checks++;
      if (got !== exp) begin
         $display("CHECK FAILED at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   function automatic logic full_of(input int b);
      return (b == 0) ? wr1_full : wr2_full;
   endfunction

   // **********************************************************************
   // stimulus helpers
   // **********************************************************************

   task automatic drive_write(input int b, input logic valid, input huf_lut_pkg::entry_kind_e kind,
                              input logic [4:0] addr, input logic [15:0] data,
                              input logic done, input logic [3:0] seq);
      if (b == 0) begin
         wr1_valid <= valid;
         wr1_kind <= kind;
         wr1_addr <= addr;
         wr1_data <= data;
         wr1_done <= done;
         wr1_seq_id <= seq;
      end else begin
         wr2_valid <= valid;
         wr2_kind <= kind;
         wr2_addr <= addr;
         wr2_data <= data;
         wr2_done <= done;
         wr2_seq_id <= seq;
      end
   endtask

   task automatic wait_full(input int b, input logic level, output int cycles);
      logic stop;
      cycles = 0;
      stop = 1'b0;
      while (!stop) begin
         @(negedge clk);
         cycles++;
         if (full_of(b) === level) begin
            stop = 1'b1;
         end else if (cycles >= wait_limit) begin
            $display("timeout: full of bank %0d never went to %0d", b + 1, level);
            aborted = 1'b1;
            stop = 1'b1;
         end
      end
   endtask

   task automatic fill_bank(input int b, input logic [3:0] seq);
      logic [15:0] v;
      huf_lut_pkg::wr_hdr_t hdr;
      int cycles;
      for (int a = 0; a < huf_lut_pkg::sym_count; a++) begin
         take_bits(16, v);
         @(posedge clk);
         drive_write(b, 1'b1, huf_lut_pkg::kind_code, a[4:0], v, 1'b0, seq);
         model_mem[b][a] = v;
      end
      take_bits(10, v);
      hdr = '0;
      hdr.hlit = v[4:0];
      hdr.hdist = v[9:5];
      // the header write shares its cycle with done
      @(posedge clk);
      drive_write(b, 1'b1, huf_lut_pkg::kind_header, 5'd0, hdr, 1'b1, seq);
      @(negedge clk);
      check_value(64'(full_of(b)), 64'd0, "full still low while done is high");
      @(posedge clk);
      drive_write(b, 1'b0, huf_lut_pkg::kind_code, 5'd0, 16'h0000, 1'b0, 4'd0);
      wait_full(b, 1'b1, cycles);
      if (aborted) return;
      check_value(64'(cycles), 64'd1, "full one cycle after done");
      model_full[b] = 1'b1;
      model_seq[b] = seq;
      model_hlit[b] = hdr.hlit;
      model_hdist[b] = hdr.hdist;
   endtask

   task automatic read_burst(input int n, input logic [3:0] seq_even, input logic [3:0] seq_odd);
      logic [15:0] v;
      logic [huf_lut_pkg::lanes-1:0][huf_lut_pkg::addr_w-1:0] a;
      for (int i = 0; i < n; i++) begin
         for (int l = 0; l < huf_lut_pkg::lanes; l++) begin
            take_bits(5, v);
            a[l] = v[4:0];
         end
         @(posedge clk);
         rd <= 1'b1;
         rd_addr <= a;
         rd_seq_id <= (i % 2 == 0) ? seq_even : seq_odd;
      end
      @(posedge clk);
      rd <= 1'b0;
      repeat (2) @(posedge clk);
   endtask

   task automatic release_seq(input int b, input logic [3:0] seq);
      int cycles;
      @(posedge clk);
      ret_ack <= 1'b1;
      rd_seq_id <= seq;
      @(negedge clk);
      check_value(64'(full_of(b)), 64'd1, "full still high while ret_ack is high");
      @(posedge clk);
      ret_ack <= 1'b0;
      wait_full(b, 1'b0, cycles);
      if (aborted) return;
      check_value(64'(cycles), 64'd1, "full falls one cycle after ret_ack");
      model_full[b] = 1'b0;
   endtask

   task automatic report_test(input int num, input string name, input int err_before);
      if (errors == err_before) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, errors - err_before);
      end
   endtask

   // responses are due one cycle after each rd; outputs settle by the falling edge
   always @(negedge clk) begin
      if (rst) begin
         pend_valid = 1'b0;
      end else begin
         cur_exp = pend_valid ? pend_exp : '0;
         check_value(64'(data_val), 64'(cur_exp.data_val), "data_val");
         check_value(64'(miss), 64'(cur_exp.miss), "miss");
         if (cur_exp.data_val) begin
            check_value(64'(rd_data), 64'(cur_exp.data), "rd_data lanes");
            check_value(64'(hlit), 64'(cur_exp.hlit), "hlit");
            check_value(64'(hdist), 64'(cur_exp.hdist), "hdist");
         end
         pend_valid = rd;
         if (rd) pend_exp = ref_lookup(rd_seq_id, rd_addr);
      end
   end

   // **********************************************************************
   // test sequence
   // **********************************************************************

   initial begin
      int err_before;
      clk = 1'b0;
      rst = 1'b1;
      drive_write(0, 1'b0, huf_lut_pkg::kind_code, 5'd0, 16'h0000, 1'b0, 4'd0);
      drive_write(1, 1'b0, huf_lut_pkg::kind_code, 5'd0, 16'h0000, 1'b0, 4'd0);
      rd = 1'b0;
      rd_addr = '0;
      rd_seq_id = '0;
      ret_ack = 1'b0;
      lfsr_state = 16'd12976;
      errors = 0;
      checks = 0;
      aborted = 1'b0;
      pend_valid = 1'b0;
      model_full[0] = 1'b0;
      model_full[1] = 1'b0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;

      err_before = errors;
      @(negedge clk);
      check_value(64'(wr1_full), 64'd0, "wr1_full after reset");
      check_value(64'(wr2_full), 64'd0, "wr2_full after reset");
      report_test(1, "reset state", err_before);

      err_before = errors;
      fill_bank(0, 4'd3);
      check_value(64'(wr2_full), 64'd0, "wr2_full while bank 1 fills");
      report_test(2, "fill and full", err_before);

      if (!aborted) begin
         err_before = errors;
         read_burst(24, 4'd3, 4'd3);
         report_test(3, "read bank 1", err_before);
      end

      if (!aborted) begin
         err_before = errors;
         fill_bank(1, 4'd5);
         read_burst(24, 4'd3, 4'd5);
         read_burst(4, 4'd7, 4'd7);
         report_test(4, "bank 2 and miss", err_before);
      end

      if (!aborted) begin
         err_before = errors;
         release_seq(0, 4'd3);
         check_value(64'(wr2_full), 64'd1, "wr2_full after seq 3 release");
         read_burst(2, 4'd3, 4'd3);
         fill_bank(0, 4'd9);
         read_burst(24, 4'd9, 4'd5);
         report_test(5, "release and refill", err_before);
      end

      $display("checks %0d, errors %0d, timeout %0d", checks, errors, aborted);
      if (errors == 0 && !aborted) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/huf_lut_top.sv
`timescale 1ns/1ps
`default_nettype none

module huf_lut_top (
   input wire logic clk,
   input wire logic rst,

   // builder port for bank 1
   input wire logic wr1_valid,
   input wire huf_lut_pkg::entry_kind_e wr1_kind,
   input wire logic [huf_lut_pkg::addr_w-1:0] wr1_addr,
   input wire huf_lut_pkg::wr_data_t wr1_data,
   input wire logic wr1_done,
   input wire logic [huf_lut_pkg::seq_w-1:0] wr1_seq_id,
   output logic wr1_full,

   // builder port for bank 2
   input wire logic wr2_valid,
   input wire huf_lut_pkg::entry_kind_e wr2_kind,
   input wire logic [huf_lut_pkg::addr_w-1:0] wr2_addr,
   input wire huf_lut_pkg::wr_data_t wr2_data,
   input wire logic wr2_done,
   input wire logic [huf_lut_pkg::seq_w-1:0] wr2_seq_id,
   output logic wr2_full,

   // symbol assigner
   input wire logic rd,
   input wire logic [huf_lut_pkg::lanes-1:0][huf_lut_pkg::addr_w-1:0] rd_addr,
   input wire logic [huf_lut_pkg::seq_w-1:0] rd_seq_id,
   input wire logic ret_ack,
   output logic data_val,
   output logic miss,
   output huf_lut_pkg::lut_entry_t [huf_lut_pkg::lanes-1:0] rd_data,
   output logic [huf_lut_pkg::hlit_w-1:0] hlit,
   output logic [huf_lut_pkg::hdist_w-1:0] hdist
);

   huf_lut_wr_if wr1_if ();
   huf_lut_wr_if wr2_if ();
   huf_lut_rd_if rd_if ();

   assign wr1_if.valid = wr1_valid;
   assign wr1_if.kind = wr1_kind;
   assign wr1_if.addr = wr1_addr;
   assign wr1_if.data = wr1_data;
   assign wr1_if.done = wr1_done;
   assign wr1_if.seq_id = wr1_seq_id;
   assign wr1_full = wr1_if.full;

   assign wr2_if.valid = wr2_valid;
   assign wr2_if.kind = wr2_kind;
   assign wr2_if.addr = wr2_addr;
   assign wr2_if.data = wr2_data;
   assign wr2_if.done = wr2_done;
   assign wr2_if.seq_id = wr2_seq_id;
   assign wr2_full = wr2_if.full;

   assign rd_if.rd = rd;
   assign rd_if.addr = rd_addr;
   assign rd_if.seq_id = rd_seq_id;
   assign rd_if.ret_ack = ret_ack;
   assign data_val = rd_if.data_val;
   assign miss = rd_if.miss;
   assign rd_data = rd_if.data;
   assign hlit = rd_if.hlit;
   assign hdist = rd_if.hdist;

   huf_lut_short short_i (
      .clk     (clk),
      .rst     (rst),
      .wr1     (wr1_if.bank),
      .wr2     (wr2_if.bank),
      .rd_port (rd_if.bank)
   );

endmodule

`default_nettype wire

// File: logic/huf_lut_short.sv
`timescale 1ns/1ps
`default_nettype none

module huf_lut_short (
   input wire logic clk,
   input wire logic rst,
   huf_lut_wr_if.bank wr1,
   huf_lut_wr_if.bank wr2,
   huf_lut_rd_if.bank rd_port
);

   huf_lut_rd_if rd_b1 ();
   huf_lut_rd_if rd_b2 ();

   // **********************************************************************
   // request fan-out
   // **********************************************************************

   // both banks see every request and decide on their own seq_id match
   assign rd_b1.rd = rd_port.rd;
   assign rd_b1.addr = rd_port.addr;
   assign rd_b1.seq_id = rd_port.seq_id;
   assign rd_b1.ret_ack = rd_port.ret_ack;

   assign rd_b2.rd = rd_port.rd;
   assign rd_b2.addr = rd_port.addr;
   assign rd_b2.seq_id = rd_port.seq_id;
   assign rd_b2.ret_ack = rd_port.ret_ack;

   huf_lut_bank bank1_i (
      .clk     (clk),
      .rst     (rst),
      .wr      (wr1),
      .rd_port (rd_b1.bank)
   );

   huf_lut_bank bank2_i (
      .clk     (clk),
      .rst     (rst),
      .wr      (wr2),
      .rd_port (rd_b2.bank)
   );

   // **********************************************************************
   // response merge
   // **********************************************************************

   // bank 1 wins if both ever answer
   always_comb begin
      rd_port.data_val = 1'b0;
      rd_port.data = '0;
      rd_port.hlit = '0;
      rd_port.hdist = '0;
      if (rd_b1.data_val) begin
         rd_port.data_val = 1'b1;
         rd_port.data = rd_b1.data;
         rd_port.hlit = rd_b1.hlit;
         rd_port.hdist = rd_b1.hdist;
      end else if (rd_b2.data_val) begin
         rd_port.data_val = 1'b1;
         rd_port.data = rd_b2.data;
         rd_port.hlit = rd_b2.hlit;
         rd_port.hdist = rd_b2.hdist;
      end
   end

   // a miss only when neither table holds the requested sequence
   assign rd_port.miss = rd_b1.miss & rd_b2.miss;

   // two full tables under one seq_id would make reads ambiguous
   a_unique_seq_id: assert property (
      @(posedge clk) disable iff (rst)
      (bank1_i.full_q && bank2_i.full_q) |-> (bank1_i.seq_q != bank2_i.seq_q)
   ) else $error("huf_lut_short: both banks full with the same seq_id");

   a_rd_ret_exclusive: assert property (
      @(posedge clk) disable iff (rst)
      !(rd_port.rd && rd_port.ret_ack)
   ) else $error("huf_lut_short: rd and ret_ack in the same cycle");

endmodule

`default_nettype wire

// File: logic/huf_lut_bank.sv
`timescale 1ns/1ps
`default_nettype none

module huf_lut_bank (
   input wire logic clk,
   input wire logic rst,
   huf_lut_wr_if.bank wr,
   huf_lut_rd_if.bank rd_port
);

   // **********************************************************************
   // storage
   // **********************************************************************

   huf_lut_pkg::lut_entry_t mem [huf_lut_pkg::sym_count];

   logic [huf_lut_pkg::hlit_w-1:0] hlit_q;
   logic [huf_lut_pkg::hdist_w-1:0] hdist_q;

   // table state
   logic full_q;
   logic [huf_lut_pkg::seq_w-1:0] seq_q;

   // read stage
   logic seq_match;
   logic hit;
   logic data_val_q;
   logic miss_q;
   huf_lut_pkg::lut_entry_t [huf_lut_pkg::lanes-1:0] data_q;
   logic [huf_lut_pkg::hlit_w-1:0] hlit_out_q;
   logic [huf_lut_pkg::hdist_w-1:0] hdist_out_q;

   // write decode
   logic wr_code;
   logic wr_header;

   assign wr_code = wr.valid && (wr.kind == huf_lut_pkg::kind_code);
   assign wr_header = wr.valid && (wr.kind == huf_lut_pkg::kind_header);

   // code entries land at the edge where valid is high
   always_ff @(posedge clk) begin
      if (wr_code) begin
         mem[wr.addr] <= wr.data.entry;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_header) begin
         hlit_q <= wr.data.hdr.hlit;
         hdist_q <= wr.data.hdr.hdist;
      end
   end

   // **********************************************************************
   // full state and sequence id
   // **********************************************************************

   assign seq_match = (rd_port.seq_id == seq_q);

   // the builder only raises done while the bank is empty, so done and a
   // release never compete for the same table
   always_ff @(posedge clk) begin
      if (rst) begin
         full_q <= 1'b0;
         seq_q <= '0;
      end else if (wr.done) begin
         full_q <= 1'b1;
         seq_q <= wr.seq_id;
      end else if (rd_port.ret_ack && full_q && seq_match) begin
         full_q <= 1'b0;
      end
   end

   assign wr.full = full_q;

   // **********************************************************************
   // read response
   // **********************************************************************

   // an empty bank never answers, whatever seq_q still holds
   assign hit = rd_port.rd && full_q && seq_match;

   always_ff @(posedge clk) begin
      if (rst) begin
         data_val_q <= 1'b0;
         miss_q <= 1'b0;
      end else begin
         data_val_q <= hit;
         miss_q <= rd_port.rd && !hit;
      end
   end

   // four independent lookups, one per lane
   always_ff @(posedge clk) begin
      if (hit) begin
         for (int i = 0; i < huf_lut_pkg::lanes; i++) begin
            data_q[i] <= mem[rd_port.addr[i]];
         end
         hlit_out_q <= hlit_q;
         hdist_out_q <= hdist_q;
      end
   end

   assign rd_port.data_val = data_val_q;
   assign rd_port.miss = miss_q;
   assign rd_port.data = data_q;
   assign rd_port.hlit = hlit_out_q;
   assign rd_port.hdist = hdist_out_q;

   // **********************************************************************
   // checks
   // **********************************************************************

   // the builder must hold off until the assigner has released the table
   a_no_write_while_full: assert property (
      @(posedge clk) disable iff (rst)
      full_q |-> !(wr.valid || wr.done)
   ) else $error("huf_lut_bank: write or done while bank is full");

endmodule

`default_nettype wire

// File: logic/huf_lut_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

// assigner-to-table read and release port
interface huf_lut_rd_if;

   // request side
   logic rd;
   logic [huf_lut_pkg::lanes-1:0][huf_lut_pkg::addr_w-1:0] addr;
   logic [huf_lut_pkg::seq_w-1:0] seq_id;
   logic ret_ack;

   // response side, one cycle behind rd
   logic data_val;
   logic miss;
   huf_lut_pkg::lut_entry_t [huf_lut_pkg::lanes-1:0] data;
   logic [huf_lut_pkg::hlit_w-1:0] hlit;
   logic [huf_lut_pkg::hdist_w-1:0] hdist;

   modport reader (
      output rd,
      output addr,
      output seq_id,
      output ret_ack,
      input data_val,
      input miss,
      input data,
      input hlit,
      input hdist
   );

   modport bank (
      input rd,
      input addr,
      input seq_id,
      input ret_ack,
      output data_val,
      output miss,
      output data,
      output hlit,
      output hdist
   );

endinterface

`default_nettype wire

// File: logic/huf_lut_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

// one builder-to-bank write port
interface huf_lut_wr_if;

   logic valid;
   huf_lut_pkg::entry_kind_e kind;
   logic [huf_lut_pkg::addr_w-1:0] addr;
   huf_lut_pkg::wr_data_t data;
   // done closes the table under seq_id
   logic done;
   logic [huf_lut_pkg::seq_w-1:0] seq_id;
   // back-pressure; no valid or done while this is high
   logic full;

   modport source (
      output valid,
      output kind,
      output addr,
      output data,
      output done,
      output seq_id,
      input full
   );

   modport bank (
      input valid,
      input kind,
      input addr,
      input data,
      input done,
      input seq_id,
      output full
   );

endinterface

`default_nettype wire

// File: logic/huf_lut_pkg.sv
`default_nettype none

package huf_lut_pkg;

   // **********************************************************************
   // table geometry
   // **********************************************************************

   localparam int sym_count = 32;
   localparam int addr_w = 5;
   localparam int lanes = 4;

   // entry and header field widths
   localparam int code_w = 12;
   localparam int len_w = 4;
   localparam int seq_w = 4;
   localparam int hlit_w = 5;
   localparam int hdist_w = 5;

   // a write carries either one entry or the two header counts
   localparam int wr_w = len_w + code_w;
   localparam int hdr_pad_w = wr_w - hdist_w - hlit_w;

   // **********************************************************************
   // write kinds and payload layouts
   // **********************************************************************

   typedef enum logic {
      kind_code = 1'b0,
      kind_header = 1'b1
   } entry_kind_e;

   // len sits above code, so the length is the top nibble
   typedef struct packed {
      logic [len_w-1:0] len;
      logic [code_w-1:0] code;
   } lut_entry_t;

   // hlit in bits 4 to 0, hdist in bits 9 to 5
   typedef struct packed {
      logic [hdr_pad_w-1:0] pad;
      logic [hdist_w-1:0] hdist;
      logic [hlit_w-1:0] hlit;
   } wr_hdr_t;

   // the builder's write word, read as entry or header by kind
   typedef union packed {
      lut_entry_t entry;
      wr_hdr_t hdr;
   } wr_data_t;

endpackage

`default_nettype wire
